//--- hw/b_operand_buffer.sv
`default_nettype none

`include "mac_settings.svh"

module b_operand_buffer
	import mac_pkg::*;
(
	input  logic                            clk,
	input  logic                            b_wr_en,
	input  logic [$clog2(`MAC_B_DEPTH)-1:0] b_wr_addr,
	input  logic [2*`MAC_LANE_W-1:0]        b_wr_data,
	input  logic [$clog2(`MAC_B_DEPTH)-1:0] b_addr,
	output b_word_u                         b_word
);

	localparam int DEPTH = `MAC_B_DEPTH;

	b_word_u mem [DEPTH];

	always_ff @(posedge clk) begin
		if (b_wr_en) begin
			mem[b_wr_addr].full <= b_wr_data;
		end
	end

	// a read in the write cycle still returns the old word
	assign b_word = mem[b_addr];

	a_wr_addr_known: assert property (
		@(posedge clk) b_wr_en |-> !$isunknown(b_wr_addr)
	) else $error("buffer write with an unknown address");

endmodule

`default_nettype wire

//--- hw/mac_pkg.sv
`default_nettype none

package mac_pkg;

	`include "mac_settings.svh"

	// the product is shifted left by the mode value times W
	typedef enum logic [1:0] {
		SHIFT_0  = 2'd0,
		SHIFT_W  = 2'd1,
		SHIFT_2W = 2'd2,
		SHIFT_3W = 2'd3
	} shift_mode_e;

	typedef struct packed {
		logic                             a_s;        // 0 takes the low half of A
		logic                             b_s;
		logic [$clog2(`MAC_B_DEPTH)-1:0]  b_addr_inc; // offset on top of the base address
		shift_mode_e                      shift_mode;
		logic                             acc_mode;   // 0 loads, 1 accumulates
	} step_ctrl_t;

	typedef struct packed {
		logic [`MAC_LANE_W-1:0] hi;
		logic [`MAC_LANE_W-1:0] lo;
	} b_halves_t;

	// written whole, read back one lane at a time
	typedef union packed {
		logic [2*`MAC_LANE_W-1:0] full;
		b_halves_t                halves;
	} b_word_u;

endpackage

`default_nettype wire

//--- hw/mac_settings.svh
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// width W of one multiplier lane, operands are 2W bits wide
`define MAC_LANE_W 4

// number of words in the B operand buffer
`define MAC_B_DEPTH 4

// number of steps in the program memory
`define MAC_STEP_DEPTH 4

`define MAC_ACC_W 20 // 2W of product plus the largest shift of 3W

// step limit, four 7-bit step words, base limit and base step
`define MAC_CONFIG_LEN 34

`endif

//--- hw/mac_step_sequencer.sv
`default_nettype none

`include "mac_settings.svh"

module mac_step_sequencer
	import mac_pkg::*;
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            hp_en,
	input  logic                            config_en,
	input  logic                            config_in,
	output logic                            config_out,
	output step_ctrl_t                      step_ctrl,
	output logic [$clog2(`MAC_B_DEPTH)-1:0] b_addr
);

	localparam int CFG_LEN  = `MAC_CONFIG_LEN;
	localparam int STEP_D   = `MAC_STEP_DEPTH;
	localparam int STEP_AW  = $clog2(STEP_D);
	localparam int B_AW     = $clog2(`MAC_B_DEPTH);
	localparam int STEP_W   = $bits(step_ctrl_t);
	localparam int WORDS_LO = STEP_AW;
	localparam int WORDS_HI = WORDS_LO + STEP_D * STEP_W - 1;
	localparam int BLIM_LO  = WORDS_HI + 1;
	localparam int BSTEP_LO = BLIM_LO + B_AW;

	logic [CFG_LEN-1:0]   cfg_chain;
	logic [STEP_AW-1:0]   step_limit;
	step_ctrl_t [STEP_D-1:0] step_words;
	logic [B_AW-1:0]      base_limit;
	logic [B_AW-1:0]      base_step;

	logic [STEP_AW-1:0]   step_cnt;
	logic [B_AW-1:0]      b_base;
	logic [B_AW:0]        base_sum;
	logic                 pass_done;

	// config_in lands in the step limit and moves towards config_out
	always_ff @(posedge clk) begin
		if (config_en) begin
			cfg_chain <= {cfg_chain[CFG_LEN-2:0], config_in};
		end
	end

	assign config_out = cfg_chain[CFG_LEN-1];

	assign step_limit = cfg_chain[STEP_AW-1:0];
	assign base_limit = cfg_chain[BLIM_LO+B_AW-1:BLIM_LO];
	assign base_step  = cfg_chain[BSTEP_LO+B_AW-1:BSTEP_LO];

	// word 0 sits next to the step limit and each word enters at a_s and leaves at acc_mode
	always_comb begin
		for (int i = 0; i < STEP_D; i++) begin
			for (int j = 0; j < STEP_W; j++) begin
				step_words[i][j] = cfg_chain[WORDS_LO + i * STEP_W + STEP_W - 1 - j];
			end
		end
	end

	assign pass_done = (step_cnt == step_limit);
	assign base_sum  = {1'b0, b_base} + {1'b0, base_step}; // one extra bit to see a pass of the limit

	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= '0;
			b_base   <= '0;
		end else if (hp_en) begin
			if (pass_done) begin
				step_cnt <= '0;
				if (base_sum > {1'b0, base_limit}) begin
					b_base <= '0;
				end else begin
					b_base <= base_sum[B_AW-1:0];
				end
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	assign step_ctrl = step_words[step_cnt];
	assign b_addr    = b_base + step_ctrl.b_addr_inc; // wraps modulo the buffer depth

	// the counter stays inside the loaded program whenever it steps
	a_step_cnt_in_range: assert property (
		@(posedge clk) disable iff (reset)
		hp_en |-> (step_cnt <= step_limit)
	) else $error("step counter ran past the step limit");

endmodule

`default_nettype wire

//--- hw/precision_mac_top.sv
`default_nettype none

`include "mac_settings.svh"

module precision_mac_top
	import mac_pkg::*;
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            hp_en,
	input  logic                            config_en,
	input  logic                            config_in,
	input  logic                            b_wr_en,
	input  logic [$clog2(`MAC_B_DEPTH)-1:0] b_wr_addr,
	input  logic [2*`MAC_LANE_W-1:0]        b_wr_data,
	input  logic [2*`MAC_LANE_W-1:0]        a_operand,
	output logic                            config_out,
	output logic [`MAC_ACC_W-1:0]           acc_value
);

	step_ctrl_t                      step_ctrl;
	logic [$clog2(`MAC_B_DEPTH)-1:0] b_addr;
	b_word_u                         b_word;

	mac_step_sequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.hp_en      (hp_en),
		.config_en  (config_en),
		.config_in  (config_in),
		.config_out (config_out),
		.step_ctrl  (step_ctrl),
		.b_addr     (b_addr)
	);

	b_operand_buffer u_b_buffer (
		.clk       (clk),
		.b_wr_en   (b_wr_en),
		.b_wr_addr (b_wr_addr),
		.b_wr_data (b_wr_data),
		.b_addr    (b_addr),
		.b_word    (b_word)
	);

	shift_accumulator u_accumulator (
		.clk       (clk),
		.reset     (reset),
		.hp_en     (hp_en),
		.step_ctrl (step_ctrl),
		.a_operand (a_operand),
		.b_word    (b_word),
		.acc_value (acc_value)
	);

endmodule

`default_nettype wire

//--- hw/shift_accumulator.sv
`default_nettype none

`include "mac_settings.svh"

module shift_accumulator
	import mac_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        hp_en,
	input  step_ctrl_t                  step_ctrl,
	input  logic [2*`MAC_LANE_W-1:0]    a_operand,
	input  b_word_u                     b_word,
	output logic [`MAC_ACC_W-1:0]       acc_value
);

	localparam int W     = `MAC_LANE_W;
	localparam int ACC_W = `MAC_ACC_W;

	logic [W-1:0]     a_half;
	logic [W-1:0]     b_half;
	logic [2*W-1:0]   product;
	logic [ACC_W-1:0] product_ext;
	logic [ACC_W-1:0] shifted;

	assign a_half = step_ctrl.a_s ? a_operand[2*W-1:W] : a_operand[W-1:0];
	assign b_half = step_ctrl.b_s ? b_word.halves.hi : b_word.halves.lo;

	assign product     = a_half * b_half; // unsigned lanes, full 2W result
	assign product_ext = {{(ACC_W-2*W){1'b0}}, product};

	always_comb begin
		case (step_ctrl.shift_mode)
			SHIFT_0:  shifted = product_ext;
			SHIFT_W:  shifted = product_ext << W;
			SHIFT_2W: shifted = product_ext << (2 * W);
			SHIFT_3W: shifted = product_ext << (3 * W);
			default:  shifted = product_ext;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_value <= '0;
		end else if (hp_en) begin
			if (step_ctrl.acc_mode) begin
				acc_value <= acc_value + shifted;
			end else begin
				acc_value <= shifted; // first step of a pass starts fresh
			end
		end
	end

	// the configuration chain has to be filled before the tile runs
	a_step_ctrl_known: assert property (
		@(posedge clk) disable iff (reset)
		hp_en |-> !$isunknown(step_ctrl)
	) else $error("step control unknown while hp_en is high");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the tile with Verilator, runs the testbench and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Mdir "$BUILD_DIR" \
	-f verilog.f --top-module precision_mac_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vprecision_mac_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	echo "testbench reported a failure, see $LOG"
	exit 1
fi

echo "no failure found in $LOG"
exit 0

//--- sim/precision_mac_tb.sv
`default_nettype none

`include "mac_settings.svh"

module precision_mac_tb;

	localparam int W        = `MAC_LANE_W;
	localparam int DW       = 2 * `MAC_LANE_W;
	localparam int AW       = $clog2(`MAC_B_DEPTH);
	localparam int ACC_W    = `MAC_ACC_W;
	localparam int CFG_L    = `MAC_CONFIG_LEN;
	localparam int BLIM_LO  = 30;
	localparam int BSTEP_LO = 32;
	localparam int TIMEOUT  = 64;

	typedef struct packed {
		logic          reset;
		logic          hp_en;
		logic          config_en;
		logic          config_in;
		logic          b_wr_en;
		logic [AW-1:0] b_wr_addr;
		logic [DW-1:0] b_wr_data;
		logic [DW-1:0] a_operand;
	} stim_t;

	logic             clk = 1'b0;
	logic             reset;
	logic             hp_en;
	logic             config_en;
	logic             config_in;
	logic             b_wr_en;
	logic [AW-1:0]    b_wr_addr;
	logic [DW-1:0]    b_wr_data;
	logic [DW-1:0]    a_operand;
	logic             config_out;
	logic [ACC_W-1:0] acc_value;

	logic [CFG_L-1:0] m_chain;
	logic [1:0]       m_cnt;
	logic [AW-1:0]    m_base;
	logic [DW-1:0]    m_mem [`MAC_B_DEPTH];
	logic [ACC_W-1:0] m_acc;
	int               m_shifts;
	stim_t            cur; // inputs the DUT samples at the coming edge
	int               errors;
	int               checks;
	bit               checks_on;
	string            test_name;

	precision_mac_top dut_i (
		.clk        (clk),
		.reset      (reset),
		.hp_en      (hp_en),
		.config_en  (config_en),
		.config_in  (config_in),
		.b_wr_en    (b_wr_en),
		.b_wr_addr  (b_wr_addr),
		.b_wr_data  (b_wr_data),
		.a_operand  (a_operand),
		.config_out (config_out),
		.acc_value  (acc_value)
	);

	always #5 clk = ~clk;

	function automatic bit with_chance(input int pct);
		return int'($urandom_range(99, 0)) < pct;
	endfunction

	// a step word travels a_s first, so the chain holds it with its bits reversed
	function automatic logic [6:0] flip_word(input logic [6:0] bits);
		logic [6:0] flipped;
		for (int i = 0; i < 7; i++) begin
			flipped[i] = bits[6 - i];
		end
		return flipped;
	endfunction

	function automatic logic [6:0] step_word(input logic a_s, input logic b_s,
		input logic [AW-1:0] inc, input logic [1:0] shift, input logic acc);
		return flip_word({a_s, b_s, inc, shift, acc});
	endfunction

	// four steps that add up the full 8x8 product, word 3 first in the vector
	function automatic logic [CFG_L-1:0] product_config(input logic [AW-1:0] inc,
		input logic [AW-1:0] blim, input logic [AW-1:0] bstep);
		return {bstep, blim,
			step_word(1'b1, 1'b1, inc, 2'd2, 1'b1),
			step_word(1'b0, 1'b1, inc, 2'd1, 1'b1),
			step_word(1'b1, 1'b0, inc, 2'd1, 1'b1),
			step_word(1'b0, 1'b0, inc, 2'd0, 1'b0),
			2'd3};
	endfunction

	function automatic void check_value(input string what, input logic [ACC_W-1:0] expected,
		input logic [ACC_W-1:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED %s %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
		end
	endfunction

	// one clock edge of the tile, computed from the state before the edge
	function automatic void advance_model();
		logic [6:0]       word;
		logic [AW-1:0]    addr;
		logic [DW-1:0]    bw;
		logic [W-1:0]     ah;
		logic [W-1:0]     bh;
		logic [ACC_W-1:0] prod;
		logic [AW:0]      sum;
		word = flip_word(m_chain[2 + 7 * int'(m_cnt) +: 7]);
		addr = m_base + word[4:3];
		bw   = m_mem[addr];
		ah   = word[6] ? cur.a_operand[DW-1:W] : cur.a_operand[W-1:0];
		bh   = word[5] ? bw[DW-1:W] : bw[W-1:0];
		prod = ACC_W'(ah) * ACC_W'(bh);
		prod = prod << (W * int'(word[2:1]));
		if (cur.reset) begin
			m_cnt  = '0;
			m_base = '0;
			m_acc  = '0;
		end else if (cur.hp_en) begin
			m_acc = word[0] ? m_acc + prod : prod;
			if (m_cnt == m_chain[1:0]) begin
				m_cnt  = '0;
				sum    = {1'b0, m_base} + {1'b0, m_chain[BSTEP_LO +: AW]};
				m_base = (sum > {1'b0, m_chain[BLIM_LO +: AW]}) ? '0 : sum[AW-1:0];
			end else begin
				m_cnt = m_cnt + 1'b1;
			end
		end
		if (cur.config_en) begin
			m_chain = {m_chain[CFG_L-2:0], cur.config_in};
			m_shifts++;
		end
		if (cur.b_wr_en) begin
			m_mem[cur.b_wr_addr] = cur.b_wr_data;
		end
	endfunction

	task automatic drive_inputs(input stim_t s);
		reset     <= s.reset;
		hp_en     <= s.hp_en;
		config_en <= s.config_en;
		config_in <= s.config_in;
		b_wr_en   <= s.b_wr_en;
		b_wr_addr <= s.b_wr_addr;
		b_wr_data <= s.b_wr_data;
		a_operand <= s.a_operand;
	endtask

	task automatic apply_cycle(input stim_t s);
		@(posedge clk);
		advance_model();
		drive_inputs(s);
		cur = s;
		@(negedge clk);
		if (checks_on) begin
			check_value("acc_value", m_acc, acc_value);
		end
		if (m_shifts >= CFG_L) begin // chain contents are only known once filled
			check_value("config_out", ACC_W'(m_chain[CFG_L-1]), ACC_W'(config_out));
		end
	endtask

	task automatic reset_tile(input int cycles);
		stim_t s;
		s       = '0;
		s.reset = 1'b1;
		repeat (cycles) begin
			apply_cycle(s);
		end
	endtask

	task automatic load_config(input logic [CFG_L-1:0] cfg);
		stim_t s;
		s           = '0;
		s.config_en = 1'b1;
		for (int i = CFG_L - 1; i >= 0; i--) begin
			s.config_in = cfg[i];
			apply_cycle(s);
		end
	endtask

	task automatic write_b(input logic [AW-1:0] addr, input logic [DW-1:0] data);
		stim_t s;
		s           = '0;
		s.b_wr_en   = 1'b1;
		s.b_wr_addr = addr;
		s.b_wr_data = data;
		apply_cycle(s);
	endtask

	// runs hp_en with random gaps until the last step of a pass has been taken
	task automatic run_pass(input logic [DW-1:0] a, input int gap_pct);
		stim_t s;
		int    n;
		bit    done;
		s           = '0;
		s.a_operand = a;
		n           = 0;
		done        = 1'b0;
		while (!done && n < TIMEOUT) begin
			s.hp_en = !with_chance(gap_pct);
			apply_cycle(s);
			done = cur.hp_en && (m_cnt == m_chain[1:0]);
			n++;
		end
		if (!done) begin
			errors++;
			$display("timeout in %s: a program pass did not finish within %0d cycles",
				test_name, TIMEOUT);
		end
		s.hp_en = 1'b0;
		apply_cycle(s);
	endtask

	task automatic fill_b(output logic [DW-1:0] words [`MAC_B_DEPTH]);
		for (int i = 0; i < `MAC_B_DEPTH; i++) begin
			words[i] = DW'($urandom);
			write_b(AW'(i), words[i]);
		end
	endtask

	initial begin
		logic [DW-1:0] a;
		logic [DW-1:0] b;
		logic [AW-1:0] addr;
		logic [AW-1:0] blim;
		int            base;
		logic [DW-1:0] b_words [`MAC_B_DEPTH];
		stim_t         s;
		void'($urandom(9));
		errors    = 0;
		checks    = 0;
		checks_on = 1'b0;
		m_chain   = '0;
		m_cnt     = '0;
		m_base    = '0;
		m_acc     = '0;
		m_shifts  = 0;
		for (int i = 0; i < `MAC_B_DEPTH; i++) begin
			m_mem[i] = '0;
		end
		cur       = '0;
		cur.reset = 1'b1;
		drive_inputs(cur);
		test_name = "reset";
		reset_tile(4);
		checks_on = 1'b1;

		test_name = "chain loop-through";
		load_config(CFG_L'({$urandom, $urandom}));
		for (int i = 0; i < 60; i++) begin
			s           = '0;
			s.config_en = with_chance(50); // config_out must hold while this is low
			s.config_in = with_chance(50);
			apply_cycle(s);
		end

		test_name = "full product";
		addr = AW'($urandom);
		load_config(product_config(addr, '0, '0));
		reset_tile(1);
		for (int i = 0; i < 8; i++) begin
			a = DW'($urandom);
			b = DW'($urandom);
			write_b(addr, b);
			run_pass(a, 30);
			check_value("product", ACC_W'(a) * ACC_W'(b), acc_value);
		end

		test_name = "base walking";
		blim = AW'($urandom);
		fill_b(b_words);
		load_config(product_config('0, blim, AW'(1)));
		reset_tile(1);
		base = 0;
		for (int p = 0; p < 10; p++) begin
			a = DW'($urandom);
			run_pass(a, 20);
			check_value("pass result", ACC_W'(a) * ACC_W'(b_words[base]), acc_value);
			base = (base + 1 > int'(blim)) ? 0 : base + 1;
		end

		test_name = "random programs";
		for (int p = 0; p < 6; p++) begin
			load_config(CFG_L'({$urandom, $urandom}));
			reset_tile(1);
			for (int i = 0; i < 80; i++) begin
				s           = '0;
				s.hp_en     = with_chance(60);
				s.a_operand = DW'($urandom);
				s.b_wr_en   = with_chance(20);
				s.b_wr_addr = AW'($urandom);
				s.b_wr_data = DW'($urandom);
				apply_cycle(s);
			end
		end

		test_name = "reset mid-program";
		fill_b(b_words);
		load_config(product_config('0, AW'(3), AW'(1)));
		reset_tile(1);
		a = DW'($urandom);
		run_pass(a, 0);
		check_value("first pass", ACC_W'(a) * ACC_W'(b_words[0]), acc_value);
		s           = '0;
		s.hp_en     = 1'b1;
		s.a_operand = a;
		apply_cycle(s);
		apply_cycle(s);
		s.reset = 1'b1; // lands halfway through the second pass
		apply_cycle(s);
		s = '0;
		apply_cycle(s);
		check_value("acc after reset", '0, acc_value);
		run_pass(a, 0);
		check_value("pass after reset", ACC_W'(a) * ACC_W'(b_words[0]), acc_value);

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/mac_pkg.sv
hw/mac_step_sequencer.sv
hw/b_operand_buffer.sv
hw/shift_accumulator.sv
hw/precision_mac_top.sv
sim/precision_mac_tb.sv
